/* Bender.yml */
package:
  name: vga_fb

sources:
  - include_dirs:
      - .
    files:
      - vgaPkg.sv
      - vgaIfs.sv
      - scanTimer.sv
      - syncFsm.sv
      - apbRegs.sv
      - frameBuffer.sv
      - pixelOut.sv
      - vgaTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbVga.sv

/* apbRegs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_cfg.svh"

module apbRegs (
  input  logic               clk,
  input  logic               rstN,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [11:0]        paddr,
  input  logic [31:0]        pwdata,
  input  logic               frameStart,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               enable,
  output vgaPkg::rgbT        fillColor,
  fbPortIf.master            fb
);

  import vgaPkg::*;

  logic access;
  logic isCtrl;
  logic isStatus;
  logic isPixel;
  logic [15:0] frameCount;
  apbWordU wrWord;
  apbWordU rdWord;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////
  assign access   = psel && penable;
  assign isCtrl   = (paddr == `VGA_ADDR_CTRL);
  assign isStatus = (paddr == `VGA_ADDR_STATUS);
  assign isPixel  = (paddr >= `VGA_ADDR_PIXEL_BASE) &&
                    (paddr < `VGA_ADDR_PIXEL_BASE + 4 * `VGA_FB_DEPTH);

  assign wrWord = pwdata;

  // No wait states
  assign pready  = 1'b1;
  // Status is read-only
  assign pslverr = access && (!(isCtrl || isStatus || isPixel) || (isStatus && pwrite));

  // Pixel port, read address already valid in the setup cycle
  assign fb.addr  = paddr[`VGA_FB_ADDR_W+1:2];
  assign fb.wdata = wrWord.pixel.color;
  assign fb.we    = access && pwrite && isPixel;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      enable    <= 1'b0;
      fillColor <= '0;
    end else if (access && pwrite && isCtrl) begin
      enable    <= wrWord.ctrl.enable;
      fillColor <= wrWord.ctrl.fillColor;
    end
  end

  // Frames shown since reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      frameCount <= '0;
    end else if (frameStart) begin
      frameCount <= frameCount + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////
  always_comb begin
    rdWord = '0;
    if (isCtrl) begin
      rdWord.ctrl.enable    = enable;
      rdWord.ctrl.fillColor = fillColor;
    end else if (isStatus) begin
      rdWord[15:0] = frameCount;
    end else if (isPixel) begin
      rdWord.pixel.color = fb.rdata;
    end
    prdata = rdWord;
  end

endmodule

`default_nettype wire

/* frameBuffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_cfg.svh"

module frameBuffer (
  input  logic                      clk,
  fbPortIf.slave                    host,
  input  logic [`VGA_FB_ADDR_W-1:0] scanAddr,
  output vgaPkg::rgbT               scanPixel
);

  import vgaPkg::*;

  rgbT mem [`VGA_FB_DEPTH];

  //////////////////////////////////////////////////
  // Host port, write-first
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (host.we) begin
      mem[host.addr] <= host.wdata;
      host.rdata     <= host.wdata;
    end else begin
      host.rdata     <= mem[host.addr];
    end
  end

  // Scan port, one cycle read
  always_ff @(posedge clk) begin
    scanPixel <= mem[scanAddr];
  end

endmodule

`default_nettype wire

/* pixelOut.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_cfg.svh"

module pixelOut (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      enable,
  input  vgaPkg::rgbT               fillColor,
  scanIf.sink                       scan,
  output logic [`VGA_FB_ADDR_W-1:0] scanAddr,
  input  vgaPkg::rgbT               scanPixel,
  output vgaPkg::rgbT               rgb,
  output logic                      hSync,
  output logic                      vSync,
  output logic                      de
);

  logic activeD;
  logic hSyncD;
  logic vSyncD;

  // Index of the pixel whose flags show up next cycle
  always_ff @(posedge clk) begin
    scanAddr <= `VGA_FB_ADDR_W'(scan.vCount * `VGA_H_ACTIVE + scan.hCount);
  end

  //////////////////////////////////////////////////
  // Match the frame buffer read latency
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      activeD <= 1'b0;
      hSyncD  <= 1'b1;
      vSyncD  <= 1'b1;
    end else begin
      activeD <= scan.active;
      hSyncD  <= scan.hSyncN;
      vSyncD  <= scan.vSyncN;
    end
  end

  // Output registers, black outside the active area
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rgb   <= '0;
      de    <= 1'b0;
      hSync <= 1'b1;
      vSync <= 1'b1;
    end else begin
      rgb   <= !activeD ? '0 : (enable ? scanPixel : fillColor);
      de    <= activeD;
      hSync <= hSyncD;
      vSync <= vSyncD;
    end
  end

endmodule

`default_nettype wire

/* scanTimer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_cfg.svh"

module scanTimer (
  input  logic clk,
  input  logic rstN,
  scanIf.timer scan
);

  // Last pixel of every line
  assign scan.lineEnd = (scan.hCount == `VGA_H_CNT_W'(`VGA_H_TOTAL - 1));

  //////////////////////////////////////////////////
  // Pixel counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      scan.hCount <= '0;
    end else if (scan.lineEnd) begin
      scan.hCount <= '0;
    end else begin
      scan.hCount <= scan.hCount + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Line counter, steps once per line
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      scan.vCount <= '0;
    end else if (scan.lineEnd) begin
      if (scan.vCount == `VGA_V_CNT_W'(`VGA_V_TOTAL - 1)) begin
        scan.vCount <= '0;
      end else begin
        scan.vCount <= scan.vCount + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
vgaPkg.sv
vgaIfs.sv
scanTimer.sv
syncFsm.sv
apbRegs.sv
frameBuffer.sv
pixelOut.sv
vgaTop.sv
tbVga.sv

/* syncFsm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_cfg.svh"

module syncFsm (
  input  logic clk,
  input  logic rstN,
  scanIf.fsm   scan,
  output logic frameStart
);

  import vgaPkg::*;

  phaseT hState;
  phaseT vState;
  phaseT hNext;
  phaseT vNext;
  logic lineEndQ;

  // Phase of a counter value, changes only at phase boundaries
  function automatic phaseT nextPhase(
    input phaseT cur,
    input int unsigned count,
    input int unsigned activeLen,
    input int unsigned frontLen,
    input int unsigned syncLen
  );
    phaseT res;
    res = cur;
    if (count == 0) begin
      res = active;
    end else if (count == activeLen) begin
      res = frontPorch;
    end else if (count == activeLen + frontLen) begin
      res = sync;
    end else if (count == activeLen + frontLen + syncLen) begin
      res = backPorch;
    end
    return res;
  endfunction

  always_comb begin
    hNext = nextPhase(hState, scan.hCount, `VGA_H_ACTIVE, `VGA_H_FRONT, `VGA_H_SYNC);
    vNext = vState;
    // First pixel of a new line, vCount already points at it
    if (lineEndQ) begin
      vNext = nextPhase(vState, scan.vCount, `VGA_V_ACTIVE, `VGA_V_FRONT, `VGA_V_SYNC);
    end
  end

  //////////////////////////////////////////////////
  // State registers, one cycle behind the counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hState     <= backPorch;
      vState     <= backPorch;
      // Reset looks like the end of the last line of a frame
      lineEndQ   <= 1'b1;
      frameStart <= 1'b0;
    end else begin
      hState     <= hNext;
      vState     <= vNext;
      lineEndQ   <= scan.lineEnd;
      frameStart <= (vNext == active) && (vState != active);
    end
  end

  assign scan.active = (hState == active) && (vState == active);
  assign scan.hSyncN = (hState != sync);
  assign scan.vSyncN = (vState != sync);

endmodule

`default_nettype wire

/* tbVga.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_cfg.svh"

module tbVga;

  import vgaPkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int TIMEOUT = 1000;
  localparam int NUM_STEPS = 17;
  localparam int SEL_H = 0;
  localparam int SEL_V = 1;
  localparam int SEL_DE = 2;

  // One APB access of the stimulus table
  typedef struct packed {
    logic wr;
    logic fromModel;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] expData;
    logic expErr;
  } apbStepT;

  logic clk;
  logic rstN;
  logic psel;
  logic penable;
  logic pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  rgbT rgb;
  logic hSync;
  logic vSync;
  logic de;

  logic [31:0] lfsr;
  rgbT model [`VGA_FB_DEPTH];
  apbStepT steps [NUM_STEPS];

  vgaTop dut (
    .clk (clk),
    .rstN (rstN),
    .psel (psel),
    .penable (penable),
    .pwrite (pwrite),
    .paddr (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr (pslverr),
    .rgb (rgb),
    .hSync (hSync),
    .vSync (vSync),
    .de (de)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Failure reporting and generic checks
  //////////////////////////////////////////////////
  task automatic failRun();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      failRun();
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [11:0] pixAddr(input int n);
    return `VGA_ADDR_PIXEL_BASE + 12'(4 * n);
  endfunction

  //////////////////////////////////////////////////
  // APB transfer with setup and access phases
  //////////////////////////////////////////////////
  task automatic apbXfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                         output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    // Middle of the access cycle
    #(CLK_PERIOD / 4);
    rdata = prdata;
    err   = pslverr;
    checkVal("pready", pready, 1'b1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apbWriteOk(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic err;
    apbXfer(1'b1, addr, data, rd, err);
    checkVal("pslverr", err, 1'b0);
  endtask

  task automatic apbReadOk(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apbXfer(1'b0, addr, 32'h0, data, err);
    checkVal("pslverr", err, 1'b0);
  endtask

  function automatic apbStepT mkStep(input logic wr, input logic fromModel,
                                     input logic [11:0] addr, input logic [31:0] data,
                                     input logic [31:0] expData, input logic expErr);
    apbStepT s;
    s.wr        = wr;
    s.fromModel = fromModel;
    s.addr      = addr;
    s.data      = data;
    s.expData   = expData;
    s.expErr    = expErr;
    return s;
  endfunction

  task automatic loadSteps();
    steps[0]  = mkStep(1'b0, 1'b0, `VGA_ADDR_CTRL, 32'h0, 32'h0, 1'b0);
    steps[1]  = mkStep(1'b1, 1'b0, `VGA_ADDR_CTRL, 32'hFFFF_FF71, 32'h0, 1'b0);
    steps[2]  = mkStep(1'b0, 1'b0, `VGA_ADDR_CTRL, 32'h0, 32'h71, 1'b0);
    steps[3]  = mkStep(1'b1, 1'b0, `VGA_ADDR_CTRL, 32'h0000_0030, 32'h0, 1'b0);
    steps[4]  = mkStep(1'b0, 1'b0, `VGA_ADDR_CTRL, 32'h0, 32'h30, 1'b0);
    steps[5]  = mkStep(1'b1, 1'b0, `VGA_ADDR_STATUS, 32'h1234, 32'h0, 1'b1);
    steps[6]  = mkStep(1'b1, 1'b0, 12'h008, 32'hDEAD, 32'h0, 1'b1);
    steps[7]  = mkStep(1'b0, 1'b0, 12'h008, 32'h0, 32'h0, 1'b1);
    steps[8]  = mkStep(1'b1, 1'b0, 12'h600, 32'h7, 32'h0, 1'b1);
    steps[9]  = mkStep(1'b0, 1'b0, 12'h600, 32'h0, 32'h0, 1'b1);
    steps[10] = mkStep(1'b0, 1'b0, 12'h3FC, 32'h0, 32'h0, 1'b1);
    // Pixel readback against the model
    steps[11] = mkStep(1'b0, 1'b1, pixAddr(0), 32'h0, 32'h0, 1'b0);
    steps[12] = mkStep(1'b0, 1'b1, pixAddr(15), 32'h0, 32'h0, 1'b0);
    steps[13] = mkStep(1'b0, 1'b1, pixAddr(16), 32'h0, 32'h0, 1'b0);
    steps[14] = mkStep(1'b0, 1'b1, pixAddr(77), 32'h0, 32'h0, 1'b0);
    steps[15] = mkStep(1'b0, 1'b1, pixAddr(127), 32'h0, 32'h0, 1'b0);
    steps[16] = mkStep(1'b0, 1'b0, `VGA_ADDR_CTRL, 32'h0, 32'h30, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Video monitors sampled on falling edges
  //////////////////////////////////////////////////
  function automatic logic sample(input int sel);
    return (sel == SEL_H) ? hSync : ((sel == SEL_V) ? vSync : de);
  endfunction

  task automatic waitForEdge(input int sel, input logic rising);
    logic prev;
    logic found;
    int n;
    found = 1'b0;
    n = 0;
    prev = sample(sel);
    while (!found && n < TIMEOUT) begin
      @(negedge clk);
      found = (sample(sel) === rising) && (prev === !rising);
      prev = sample(sel);
      n++;
    end
    assert (found) else begin
      $display("Timeout: no edge seen on video signal %0d within %0d cycles", sel, TIMEOUT);
      failRun();
    end
  endtask

  // Cycles the signal holds its level from the current sample on
  task automatic runLength(input int sel, input logic level, output int n);
    n = 1;
    @(negedge clk);
    while (sample(sel) === level && n < TIMEOUT) begin
      n++;
      @(negedge clk);
    end
    assert (n < TIMEOUT) else begin
      $display("Timeout: video signal %0d stuck for %0d cycles", sel, TIMEOUT);
      failRun();
    end
  endtask

  // Begins at the sample where vSync has just risen
  task automatic checkFrame(input logic useModel, input rgbT fill);
    int line;
    int col;
    logic expDe;
    logic expH;
    rgbT expRgb;
    for (int k = 0; k < (`VGA_V_BACK + `VGA_V_ACTIVE) * `VGA_H_TOTAL; k++) begin
      if (k > 0) begin
        @(negedge clk);
      end
      line  = k / `VGA_H_TOTAL;
      col   = k % `VGA_H_TOTAL;
      expDe = (line >= `VGA_V_BACK) && (col < `VGA_H_ACTIVE);
      expH  = !((col >= `VGA_H_ACTIVE + `VGA_H_FRONT) &&
                (col < `VGA_H_ACTIVE + `VGA_H_FRONT + `VGA_H_SYNC));
      expRgb = '0;
      if (expDe) begin
        expRgb = useModel ? model[(line - `VGA_V_BACK) * `VGA_H_ACTIVE + col] : fill;
      end
      checkVal("de", de, expDe);
      checkVal("hSync", hSync, expH);
      checkVal("vSync", vSync, 1'b1);
      checkVal("rgb", rgb, expRgb);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic [31:0] bits;
    logic [31:0] expData;
    logic [31:0] countA;
    logic [31:0] countB;
    logic err;
    int n;
    rstN    = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    lfsr    = 32'ha4c2_a043;
    repeat (8) @(negedge clk);
    rstN = 1'b1;

    // Output registers keep their reset values until the next rising edge
    checkVal("hSync", hSync, 1'b1);
    checkVal("vSync", vSync, 1'b1);
    checkVal("de", de, 1'b0);
    checkVal("rgb", rgb, 3'd0);

    for (int i = 0; i < `VGA_FB_DEPTH; i++) begin
      takeBits(3, bits);
      model[i] = bits[2:0];
      apbWriteOk(pixAddr(i), bits);
    end

    loadSteps();
    for (int s = 0; s < NUM_STEPS; s++) begin
      expData = steps[s].expData;
      if (steps[s].fromModel) begin
        expData = {29'b0, model[(steps[s].addr - `VGA_ADDR_PIXEL_BASE) >> 2]};
      end
      apbXfer(steps[s].wr, steps[s].addr, steps[s].data, rd, err);
      checkVal("pslverr", err, steps[s].expErr);
      if (!steps[s].wr) begin
        checkVal("prdata", rd, expData);
      end
    end

    // Sync pulse widths and periods
    waitForEdge(SEL_H, 1'b0);
    runLength(SEL_H, 1'b0, n);
    checkVal("hSync low cycles", n, `VGA_H_SYNC);
    runLength(SEL_H, 1'b1, n);
    checkVal("hSync period", n + `VGA_H_SYNC, `VGA_H_TOTAL);
    waitForEdge(SEL_V, 1'b0);
    runLength(SEL_V, 1'b0, n);
    checkVal("vSync low cycles", n, `VGA_V_SYNC * `VGA_H_TOTAL);
    runLength(SEL_V, 1'b1, n);
    checkVal("vSync period", n + `VGA_V_SYNC * `VGA_H_TOTAL, `VGA_V_TOTAL * `VGA_H_TOTAL);
    waitForEdge(SEL_DE, 1'b1);
    runLength(SEL_DE, 1'b1, n);
    checkVal("de high cycles", n, `VGA_H_ACTIVE);

    // Frame buffer scan-out
    apbWriteOk(`VGA_ADDR_CTRL, 32'h0000_0001);
    waitForEdge(SEL_V, 1'b1);
    checkFrame(1'b1, 3'd0);

    // Fill colour 5 with the buffer disabled
    apbWriteOk(`VGA_ADDR_CTRL, 32'h0000_0050);
    waitForEdge(SEL_V, 1'b1);
    checkFrame(1'b0, 3'd5);

    waitForEdge(SEL_V, 1'b1);
    apbReadOk(`VGA_ADDR_STATUS, countA);
    waitForEdge(SEL_V, 1'b1);
    apbReadOk(`VGA_ADDR_STATUS, countB);
    checkVal("frameCount step", countB - countA, 32'd1);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* vgaIfs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_cfg.svh"

// Raster position and the decoded phase flags
interface scanIf;
  logic [`VGA_H_CNT_W-1:0] hCount;
  logic [`VGA_V_CNT_W-1:0] vCount;
  logic lineEnd;
  logic active;
  logic hSyncN;
  logic vSyncN;

  modport timer (output hCount, vCount, lineEnd);
  modport fsm (input hCount, vCount, lineEnd, output active, hSyncN, vSyncN);
  modport sink (input hCount, vCount, active, hSyncN, vSyncN);
endinterface

// Host side port of the frame buffer
interface fbPortIf;
  import vgaPkg::*;

  logic we;
  logic [`VGA_FB_ADDR_W-1:0] addr;
  rgbT wdata;
  rgbT rdata;

  modport master (output we, addr, wdata, input rdata);
  modport slave (input we, addr, wdata, output rdata);
endinterface

`default_nettype wire

/* vgaPkg.sv */
`default_nettype none

package vgaPkg;

  // Red in bit 2, green in bit 1, blue in bit 0
  typedef logic [2:0] rgbT;

  // Phases of one line or one frame, in scan order
  typedef enum logic [1:0] {
    active,
    frontPorch,
    sync,
    backPorch
  } phaseT;

  //////////////////////////////////////////////////
  // APB data word views
  //////////////////////////////////////////////////

  // Pixel region word
  typedef struct packed {
    logic [28:0] rsvd;
    rgbT color;
  } pixelViewT;

  // Control register word
  typedef struct packed {
    logic [24:0] rsvd1;
    rgbT fillColor;
    logic [2:0] rsvd0;
    logic enable;
  } ctrlViewT;

  // Same pwdata word, decoded by address
  typedef union packed {
    pixelViewT pixel;
    ctrlViewT ctrl;
  } apbWordU;

endpackage

`default_nettype wire

/* vgaTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "vga_cfg.svh"

module vgaTop (
  input  logic        clk,
  input  logic        rstN,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output vgaPkg::rgbT rgb,
  output logic        hSync,
  output logic        vSync,
  output logic        de
);

  import vgaPkg::*;

  logic frameStart;
  logic enable;
  rgbT fillColor;
  logic [`VGA_FB_ADDR_W-1:0] scanAddr;
  rgbT scanPixel;

  scanIf scan ();
  fbPortIf fb ();

  //////////////////////////////////////////////////
  // Raster timing
  //////////////////////////////////////////////////
  scanTimer uTimer (
    .clk (clk),
    .rstN (rstN),
    .scan (scan.timer)
  );

  syncFsm uSync (
    .clk (clk),
    .rstN (rstN),
    .scan (scan.fsm),
    .frameStart (frameStart)
  );

  //////////////////////////////////////////////////
  // Host registers and pixel memory
  //////////////////////////////////////////////////
  apbRegs uRegs (
    .clk (clk),
    .rstN (rstN),
    .psel (psel),
    .penable (penable),
    .pwrite (pwrite),
    .paddr (paddr),
    .pwdata (pwdata),
    .frameStart (frameStart),
    .prdata (prdata),
    .pready (pready),
    .pslverr (pslverr),
    .enable (enable),
    .fillColor (fillColor),
    .fb (fb.master)
  );

  frameBuffer uFb (
    .clk (clk),
    .host (fb.slave),
    .scanAddr (scanAddr),
    .scanPixel (scanPixel)
  );

  // Video output stage
  pixelOut uOut (
    .clk (clk),
    .rstN (rstN),
    .enable (enable),
    .fillColor (fillColor),
    .scan (scan.sink),
    .scanAddr (scanAddr),
    .scanPixel (scanPixel),
    .rgb (rgb),
    .hSync (hSync),
    .vSync (vSync),
    .de (de)
  );

endmodule

`default_nettype wire

/* vga_cfg.svh */
`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

//////////////////////////////////////////////////
// Horizontal timing in pixels
//////////////////////////////////////////////////
`define VGA_H_ACTIVE 16
`define VGA_H_FRONT 2
`define VGA_H_SYNC 4
`define VGA_H_BACK 2
`define VGA_H_TOTAL (`VGA_H_ACTIVE + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK)
`define VGA_H_CNT_W 5

//////////////////////////////////////////////////
// Vertical timing in lines
//////////////////////////////////////////////////
`define VGA_V_ACTIVE 8
`define VGA_V_FRONT 1
`define VGA_V_SYNC 2
`define VGA_V_BACK 1
`define VGA_V_TOTAL (`VGA_V_ACTIVE + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK)
`define VGA_V_CNT_W 4

// Frame buffer geometry
`define VGA_FB_DEPTH 128
`define VGA_FB_ADDR_W 7

// APB byte addresses
`define VGA_ADDR_CTRL 12'h000
`define VGA_ADDR_STATUS 12'h004
`define VGA_ADDR_PIXEL_BASE 12'h400

`endif
